/* clk_resync_pkg.sv */
`default_nettype none

package clk_resync_pkg;

	//--------------------------------------------------------------------------
	// Hold-off timing
	//--------------------------------------------------------------------------
	localparam int HOLDOFF_US_DEF = 100;	// Hold-off after each capture, in us
	localparam int CYC_PER_US_DEF = 40;	// CLK40 cycles in one microsecond

	// Depth of the stretch applied to the sampling clock manager reset
	localparam int RST_PIPE_LEN = 8;

	//--------------------------------------------------------------------------
	// Output values while RST is asserted
	//--------------------------------------------------------------------------
	localparam logic SAMP_RST_INIT  = 1'b1;	// Sampling clock manager held in reset
	localparam logic CLK20_SEL_INIT = 1'b0;	// Non-inverted 20 MHz phase
	localparam logic DSR_INIT       = 1'b0;	// No hold-off

	// Bits needed for a counter that runs from 0 up to max_val
	function automatic int cnt_width(input int max_val);
		int w;
		w = 1;
		while ((2 ** w) <= max_val) begin
			w++;
		end
		return w;
	endfunction

endpackage

`default_nettype wire

/* cmp_phase_pkg.sv */
`default_nettype none

package cmp_phase_pkg;

	//--------------------------------------------------------------------------
	// Comparator clock phase widths
	//--------------------------------------------------------------------------
	localparam int SEL_W       = 5;		// Coarse setting, 32 positions
	localparam int PHASE_W     = 11;	// Fine step count
	localparam int TABLE_DEPTH = 2 ** SEL_W;

	// 25 ns period / (1/56 of a 960 MHz VCO period)
	localparam int STEPS_PER_CYCLE = 1344;

	// Cycles spent after each done reply, covers the change flag delay
	localparam int SETTLE_CYC = 2;

	typedef logic [PHASE_W-1:0] cmp_phase_t;

	// Phase shift sequencer states
	typedef enum logic [2:0] {
		PS_IDLE   = 3'd0,
		PS_STEP   = 3'd1,
		PS_WAIT   = 3'd2,
		PS_SETTLE = 3'd3
	} phs_state_t;

	// Table entry: nearest integer of idx * 1344 / 31
	// Top entry lands on a full period
	function automatic cmp_phase_t phase_entry(input int unsigned idx);
		int unsigned scaled;
		int unsigned div;
		div = TABLE_DEPTH - 1;
		scaled = idx * STEPS_PER_CYCLE;
		return cmp_phase_t'((scaled + div / 2) / div);
	endfunction

endpackage

`default_nettype wire

/* resync_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module resync_ctrl #(
	parameter int HOLDOFF_US = clk_resync_pkg::HOLDOFF_US_DEF,
	parameter int CYC_PER_US = clk_resync_pkg::CYC_PER_US_DEF
) (
	input  wire  CLK40,
	input  wire  RST,
	input  wire  resync_i,
	input  wire  samp_phs_chng_i,
	input  wire  samp_half_sel_i,
	output logic lead_edge_o,
	output logic cap_phase_o,
	output logic samp_mmcm_rst_o,
	output logic dsr_resync_o,
	output logic clk20_sel_o,
	output logic samp_in_sel_o
);

	import clk_resync_pkg::*;

	localparam int PRE_W = cnt_width(CYC_PER_US - 1);
	localparam int US_W  = cnt_width(HOLDOFF_US);

	logic [1:0]              rst_dly;		// RST seen one and two edges back
	logic                    resync_d1;
	logic                    lead_edge_d1;
	logic                    trl_rst;
	logic                    pipe_in;
	logic [RST_PIPE_LEN-1:0] rst_pipe;
	logic                    clk20_phase;
	logic [PRE_W-1:0]        pre_cnt;
	logic [US_W-1:0]         us_cnt;
	logic                    pre_wrap;
	logic                    clr_dsr;

	//--------------------------------------------------------------------------
	// Edge detection and capture pulse
	//--------------------------------------------------------------------------
	assign lead_edge_o = resync_i & ~resync_d1;	// One cycle wide
	assign trl_rst     = ~RST & rst_dly[1];	// First two edges after release
	assign pipe_in     = lead_edge_o | trl_rst | cap_phase_o | samp_phs_chng_i;

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			rst_dly      <= 2'b11;
			resync_d1    <= 1'b0;
			lead_edge_d1 <= 1'b0;
			cap_phase_o  <= 1'b0;
			rst_pipe     <= {RST_PIPE_LEN{SAMP_RST_INIT}};
		end else begin
			rst_dly      <= {rst_dly[0], 1'b0};
			resync_d1    <= resync_i;
			lead_edge_d1 <= lead_edge_o;
			cap_phase_o  <= lead_edge_o | lead_edge_d1 | trl_rst | samp_phs_chng_i;
			rst_pipe     <= {rst_pipe[RST_PIPE_LEN-2:0], pipe_in};
		end
	end

	// Stretched reset for the sampling clock manager
	assign samp_mmcm_rst_o = |rst_pipe;

	// 20 MHz phase, realigned on every resync
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			clk20_phase <= 1'b0;
			clk20_sel_o <= CLK20_SEL_INIT;
		end else begin
			clk20_phase <= lead_edge_o ? 1'b0 : ~clk20_phase;
			if (cap_phase_o) begin
				clk20_sel_o <= clk20_phase;	// Latch phase on capture
			end
		end
	end

	assign samp_in_sel_o = clk20_sel_o ^ samp_half_sel_i;

	//--------------------------------------------------------------------------
	// Hold-off flag with microsecond prescaler
	//--------------------------------------------------------------------------
	assign pre_wrap = (pre_cnt == PRE_W'(CYC_PER_US - 1));
	assign clr_dsr  = (us_cnt == US_W'(HOLDOFF_US));

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			dsr_resync_o <= DSR_INIT;
			pre_cnt      <= '0;
			us_cnt       <= '0;
		end else if (cap_phase_o) begin	// Restart on every capture
			dsr_resync_o <= 1'b1;
			pre_cnt      <= '0;
			us_cnt       <= '0;
		end else if (dsr_resync_o) begin
			dsr_resync_o <= ~clr_dsr;
			pre_cnt      <= pre_wrap ? '0 : pre_cnt + 1'b1;
			us_cnt       <= us_cnt + US_W'(pre_wrap);
		end else begin
			pre_cnt <= '0;
			us_cnt  <= '0;
		end
	end

endmodule

`default_nettype wire

/* cmp_phase_cfg.sv */
`timescale 1ns/1ps
`default_nettype none

module cmp_phase_cfg (
	input  wire                            CLK40,
	input  wire                            RST,
	input  wire [cmp_phase_pkg::SEL_W-1:0] cmp_clk_phase_i,
	input  wire                            ps_en_i,
	output cmp_phase_pkg::cmp_phase_t      target_o,
	output cmp_phase_pkg::cmp_phase_t      cur_phase_o,
	output logic                           phs_inc_o,
	output logic                           phs_change_o
);

	import cmp_phase_pkg::*;

	cmp_phase_t phase_rom [TABLE_DEPTH];
	logic       phs_chg_m1;

	//--------------------------------------------------------------------------
	// Coarse setting to fine step lookup
	//--------------------------------------------------------------------------
	for (genvar g = 0; g < TABLE_DEPTH; g++) begin : g_rom
		assign phase_rom[g] = phase_entry(g);	// Constant entry
	end

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			target_o <= '0;
		end else begin
			target_o <= phase_rom[cmp_clk_phase_i];
		end
	end

	// Direction and change request
	// The change flag trails the compare by two cycles so that a step
	// just taken has reached cur_phase_o before it is looked at again
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			phs_inc_o    <= 1'b0;
			phs_chg_m1   <= 1'b0;
			phs_change_o <= 1'b0;
		end else begin
			phs_inc_o    <= (target_o > cur_phase_o);
			phs_chg_m1   <= (target_o != cur_phase_o);
			phs_change_o <= phs_chg_m1;
		end
	end

	//--------------------------------------------------------------------------
	// Phase presumed to be held by the clock manager
	//--------------------------------------------------------------------------
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			cur_phase_o <= '0;	// Clock manager starts at zero offset
		end else if (ps_en_i) begin
			if (phs_inc_o) begin
				cur_phase_o <= cur_phase_o + 1'b1;
			end else begin
				cur_phase_o <= cur_phase_o - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* cmp_phase_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module cmp_phase_fsm (
	input  wire                       CLK40,
	input  wire                       RST,
	input  wire                       phs_change_i,
	input  wire                       locked_i,
	input  wire                       ps_done_i,
	output logic                      ps_en_o,
	output logic                      busy_o,
	output cmp_phase_pkg::phs_state_t state_o
);

	import cmp_phase_pkg::*;

	localparam int CNT_W = $clog2(SETTLE_CYC + 1);

	phs_state_t       state;
	phs_state_t       state_nxt;
	logic [CNT_W-1:0] settle_cnt;
	logic             settle_done;

	assign settle_done = (settle_cnt == CNT_W'(SETTLE_CYC - 1));

	//--------------------------------------------------------------------------
	// Next state
	//--------------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			PS_IDLE: begin
				if (locked_i && phs_change_i) begin
					state_nxt = PS_STEP;
				end
			end
			PS_STEP: begin
				state_nxt = PS_WAIT;	// Single enable strobe
			end
			PS_WAIT: begin
				if (ps_done_i) begin	// No timeout on the reply
					state_nxt = PS_SETTLE;
				end
			end
			PS_SETTLE: begin
				if (settle_done) begin
					state_nxt = PS_IDLE;
				end
			end
			default: begin
				state_nxt = PS_IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			state <= PS_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Settle counter, runs only in PS_SETTLE
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			settle_cnt <= '0;
		end else if (state == PS_SETTLE) begin
			settle_cnt <= settle_cnt + 1'b1;
		end else begin
			settle_cnt <= '0;
		end
	end

	//--------------------------------------------------------------------------
	// Outputs
	//--------------------------------------------------------------------------
	assign ps_en_o = (state == PS_STEP);
	assign busy_o  = (state != PS_IDLE);	// Falls when the step is complete
	assign state_o = state;

endmodule

`default_nettype wire

/* clock_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_ctrl_top #(
	parameter int HOLDOFF_US = clk_resync_pkg::HOLDOFF_US_DEF,
	parameter int CYC_PER_US = clk_resync_pkg::CYC_PER_US_DEF
) (
	input  wire                              CLK40,
	input  wire                              RST,
	// Resync control
	input  wire                              resync_i,
	input  wire                              samp_phs_chng_i,
	input  wire                              samp_half_sel_i,	// Sampling phase bit 2
	output logic                             lead_edge_o,
	output logic                             cap_phase_o,
	output logic                             samp_mmcm_rst_o,
	output logic                             dsr_resync_o,
	output logic                             clk20_sel_o,
	output logic                             samp_in_sel_o,
	// Comparator phase stepping
	input  wire [cmp_phase_pkg::SEL_W-1:0]   cmp_clk_phase_i,
	input  wire                              mmcm_locked_i,
	input  wire                              ps_done_i,
	output cmp_phase_pkg::cmp_phase_t        cmp_phase_o,
	output cmp_phase_pkg::cmp_phase_t        cur_phase_o,
	output logic                             cmp_phs_change_o,
	output logic                             ps_en_o,
	output logic                             ps_incdec_o,
	output logic                             busy_o,
	output cmp_phase_pkg::phs_state_t        phs_state_o
);

	//--------------------------------------------------------------------------
	// Resync, capture and hold-off
	//--------------------------------------------------------------------------
	resync_ctrl #(
		.HOLDOFF_US (HOLDOFF_US),
		.CYC_PER_US (CYC_PER_US)
	) resync_ctrl_i (
		.CLK40           (CLK40),
		.RST             (RST),
		.resync_i        (resync_i),
		.samp_phs_chng_i (samp_phs_chng_i),
		.samp_half_sel_i (samp_half_sel_i),
		.lead_edge_o     (lead_edge_o),
		.cap_phase_o     (cap_phase_o),
		.samp_mmcm_rst_o (samp_mmcm_rst_o),
		.dsr_resync_o    (dsr_resync_o),
		.clk20_sel_o     (clk20_sel_o),
		.samp_in_sel_o   (samp_in_sel_o)
	);

	//--------------------------------------------------------------------------
	// Comparator clock phase, table and tracker beside the sequencer
	//--------------------------------------------------------------------------
	cmp_phase_cfg cmp_phase_cfg_i (
		.CLK40           (CLK40),
		.RST             (RST),
		.cmp_clk_phase_i (cmp_clk_phase_i),
		.ps_en_i         (ps_en_o),
		.target_o        (cmp_phase_o),
		.cur_phase_o     (cur_phase_o),
		.phs_inc_o       (ps_incdec_o),
		.phs_change_o    (cmp_phs_change_o)
	);

	cmp_phase_fsm cmp_phase_fsm_i (
		.CLK40        (CLK40),
		.RST          (RST),
		.phs_change_i (cmp_phs_change_o),
		.locked_i     (mmcm_locked_i),
		.ps_done_i    (ps_done_i),
		.ps_en_o      (ps_en_o),
		.busy_o       (busy_o),
		.state_o      (phs_state_o)
	);

endmodule

`default_nettype wire

/* clock_ctrl_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_ctrl_assertions (
	input wire CLK40,
	input wire RST,
	input wire ps_en,
	input wire ps_done,
	input wire cap_phase,
	input wire samp_rst
);

	import clk_resync_pkg::*;

	logic done_pend;	// Enable issued, done reply still outstanding

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			done_pend <= 1'b0;
		end else if (ps_en) begin
			done_pend <= 1'b1;
		end else if (ps_done) begin
			done_pend <= 1'b0;
		end
	end

	// Enable is a single-cycle strobe
	a_en_single : assert property (@(posedge CLK40) disable iff (RST)
		ps_en |=> !ps_en)
		else $error("ps_en_o high for two cycles");

	// No new step while the done reply is outstanding
	a_no_en_in_wait : assert property (@(posedge CLK40) disable iff (RST)
		ps_en |-> !done_pend)
		else $error("ps_en_o issued before the done reply");

	// Sampling reset stretched by the full pipe after each capture
	a_rst_stretch : assert property (@(posedge CLK40) disable iff (RST)
		$fell(cap_phase) |-> samp_rst [*RST_PIPE_LEN])
		else $error("samp_mmcm_rst_o shorter than the reset pipe");

endmodule

bind clock_ctrl_top clock_ctrl_assertions assertions_i (
	.CLK40     (CLK40),
	.RST       (RST),
	.ps_en     (ps_en_o),
	.ps_done   (ps_done_i),
	.cap_phase (cap_phase_o),
	.samp_rst  (samp_mmcm_rst_o)
);

`default_nettype wire

/* tb_clock_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_ctrl;

	import clk_resync_pkg::*;
	import cmp_phase_pkg::*;

	localparam int TMO = 20000;	// Cycle limit for every wait

	logic CLK40;
	logic RST;
	logic resync_i;
	logic samp_phs_chng_i;
	logic samp_half_sel_i;
	logic [SEL_W-1:0] cmp_clk_phase_i;
	logic mmcm_locked_i;
	logic ps_done_i;
	logic lead_edge_o, cap_phase_o, samp_mmcm_rst_o, dsr_resync_o, clk20_sel_o, samp_in_sel_o;
	cmp_phase_t cmp_phase_o;
	cmp_phase_t cur_phase_o;
	logic cmp_phs_change_o, ps_en_o, ps_incdec_o, busy_o;
	phs_state_t phs_state_o;

	int err_cnt, test_err0, test_cnt, test_fail, since_cap;
	logic [127:0] test_name;
	logic tog, sel_exp, en_seen, dir_seen, lock_seen;
	logic cap_seen, dsr_seen, timed_out;
	cmp_phase_t cur_seen;
	cmp_phase_t tgt_exp;	// Target from the trace
	logic [31:0] rng = 32'hc5fcf215;

	clock_ctrl_top #(.HOLDOFF_US(4), .CYC_PER_US(40)) dut_i (.*);

	initial begin
		CLK40 = 1'b0;
		forever #5 CLK40 = ~CLK40;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic tick;
		@(posedge CLK40);
		#1;
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			err_cnt++;
			$display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_phase(input string what, input cmp_phase_t got,
		input cmp_phase_t exp);
		if (got !== exp) begin
			err_cnt++;
			$display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_state(input string what, input phs_state_t got,
		input phs_state_t exp);
		if (got !== exp) begin
			err_cnt++;
			$display("error at %0t ns: %s is %s, expected %s", $time, what,
				got.name(), exp.name());
		end
	endtask

	task automatic check_count(input string what, input int got, input int lo, input int hi);
		if (got < lo || got > hi) begin
			err_cnt++;
			$display("error at %0t ns: %s is %0d, expected %0d to %0d", $time, what,
				got, lo, hi);
		end
	endtask

	task automatic report_timeout(input string what);
		err_cnt++;
		timed_out = 1'b1;
		$display("Timeout while waiting for %s", what);
	endtask

	task automatic close_test;
		if (test_cnt > 0) begin
			if (err_cnt == test_err0) begin
				$display("test %0s: ok", test_name);
			end else begin
				test_fail++;
				$display("test %0s: %0d errors", test_name, err_cnt - test_err0);
			end
		end
	endtask

	//--------------------------------------------------------------------------
	// Reference model of the 20 MHz select and enable monitor, at negedge
	//--------------------------------------------------------------------------
	always @(negedge CLK40) begin
		if (RST) begin
			tog = 1'b0;
			sel_exp = 1'b0;
			en_seen = 1'b0;
			cap_seen = 1'b0;
			dsr_seen = 1'b0;
			since_cap = 0;
		end else begin
			check_bit("clk20_sel_o", clk20_sel_o, sel_exp);
			check_bit("samp_in_sel_o", samp_in_sel_o, sel_exp ^ samp_half_sel_i);
			// Hold-off flag only rises the cycle after a capture
			if (cap_seen) begin
				check_bit("dsr_resync_o after capture", dsr_resync_o, 1'b1);
			end else if (!dsr_seen) begin
				check_bit("dsr_resync_o without capture", dsr_resync_o, 1'b0);
			end
			if (cap_phase_o) begin
				sel_exp = tog;	// Select latched on capture
			end
			tog = lead_edge_o ? 1'b0 : ~tog;
			since_cap = cap_phase_o ? 0 : since_cap + 1;
			if (en_seen) begin
				check_phase("cur_phase_o step", cur_phase_o,
					dir_seen ? cur_seen + 1'b1 : cur_seen - 1'b1);
			end
			if (ps_en_o) begin
				check_bit("ps_incdec_o", ps_incdec_o, tgt_exp > cur_phase_o);
				if (!lock_seen) begin
					err_cnt++;
					$display("error at %0t ns: enable issued while unlocked", $time);
				end
			end
			en_seen = ps_en_o;
			cur_seen = cur_phase_o;
			dir_seen = tgt_exp > cur_phase_o;	// Step toward the target
			cap_seen = cap_phase_o;
			dsr_seen = dsr_resync_o;
		end
		lock_seen = mmcm_locked_i;
	end

	// Clock manager model, done a random 1 to 6 cycles after each enable
	initial begin : done_model
		int unsigned dly;
		forever begin
			tick();
			if (ps_en_o) begin
				rng = xorshift(rng);
				dly = (rng % 6) + 1;
				repeat (dly) tick();
				ps_done_i = 1'b1;
				tick();
				ps_done_i = 1'b0;
			end
		end
	end

	//--------------------------------------------------------------------------
	// Trace commands
	//--------------------------------------------------------------------------
	task automatic run_reset;
		RST = 1'b1;
		repeat (16) tick();
		check_bit("busy_o in reset", busy_o, 1'b0);
		check_bit("dsr_resync_o in reset", dsr_resync_o, 1'b0);
		RST = 1'b0;
		tick();
		check_bit("cap_phase_o after release", cap_phase_o, 1'b1);
		tick();
		check_bit("cap_phase_o after release", cap_phase_o, 1'b1);
		tick();
		check_bit("cap_phase_o end", cap_phase_o, 1'b0);
		for (int n = 0; n <= TMO; n++) begin
			if (!samp_mmcm_rst_o) begin
				check_count("reset pipe length", n, RST_PIPE_LEN, RST_PIPE_LEN);
				return;
			end
			tick();
		end
		report_timeout("samp_mmcm_rst_o to fall");
	endtask

	task automatic pulse_resync(input int hold);
		resync_i = 1'b1;
		#1;
		check_bit("lead_edge_o", lead_edge_o, 1'b1);
		tick();
		check_bit("lead_edge_o", lead_edge_o, 1'b0);
		check_bit("cap_phase_o", cap_phase_o, 1'b1);
		tick();
		check_bit("cap_phase_o", cap_phase_o, 1'b1);
		tick();
		check_bit("cap_phase_o", cap_phase_o, 1'b0);
		check_bit("clk20_sel_o after resync", clk20_sel_o, sel_exp);
		repeat (hold) begin
			tick();
			check_bit("lead_edge_o while held", lead_edge_o, 1'b0);
		end
		resync_i = 1'b0;
	endtask

	task automatic pulse_phs_chng;
		samp_phs_chng_i = 1'b1;
		tick();
		check_bit("cap_phase_o on change", cap_phase_o, 1'b1);
		samp_phs_chng_i = 1'b0;
		tick();
		check_bit("cap_phase_o on change", cap_phase_o, 1'b0);
	endtask

	task automatic measure_holdoff(input int exp);
		for (int n = 0; n <= TMO; n++) begin
			if (!dsr_resync_o) begin
				check_count("hold-off length", since_cap, exp - 1, exp + 1);
				return;
			end
			tick();
		end
		report_timeout("dsr_resync_o to fall");
	endtask

	task automatic wait_phase_done(input cmp_phase_t exp);
		// Change flag trails the target compare by two cycles
		repeat (2) tick();
		for (int n = 0; n <= TMO; n++) begin
			if (!busy_o && !cmp_phs_change_o) begin
				check_phase("cur_phase_o final", cur_phase_o, exp);
				check_state("phs_state_o final", phs_state_o, PS_IDLE);
				return;
			end
			tick();
		end
		report_timeout("phase stepping to end");
	endtask

	initial begin : main
		int fd, rc, a, b;
		logic [127:0] cmd;
		logic [1023:0] line;
		RST = 1'b1;
		resync_i = 1'b0;
		samp_phs_chng_i = 1'b0;
		samp_half_sel_i = 1'b0;
		cmp_clk_phase_i = '0;
		mmcm_locked_i = 1'b0;
		ps_done_i = 1'b0;
		tgt_exp = '0;
		timed_out = 1'b0;
		fd = $fopen("clock_ctrl_trace.txt", "r");
		if (fd == 0) begin
			err_cnt++;
			$display("Cannot open clock_ctrl_trace.txt");
		end else begin
			while (!timed_out) begin
				rc = $fscanf(fd, "%s", cmd);
				if (rc != 1 || cmd == "END") break;
				if (cmd == "#") begin
					rc = $fgets(line, fd);
				end else if (cmd == "TEST") begin
					close_test();
					rc = $fscanf(fd, "%s", test_name);
					test_cnt++;
					test_err0 = err_cnt;
				end else if (cmd == "RESET") begin
					run_reset();
				end else if (cmd == "CHNG") begin
					pulse_phs_chng();
				end else begin
					rc = $fscanf(fd, "%d", a);
					if (cmd == "LOCK") begin
						mmcm_locked_i = a[0];
					end else if (cmd == "HALF") begin
						samp_half_sel_i = a[0];
						#1;
						check_bit("samp_in_sel_o", samp_in_sel_o, sel_exp ^ a[0]);
					end else if (cmd == "RESYNC") begin
						pulse_resync(a);
					end else if (cmd == "HOLDOFF") begin
						measure_holdoff(a);
					end else if (cmd == "DSRHI") begin
						repeat (a) begin
							tick();
							check_bit("dsr_resync_o in window", dsr_resync_o, 1'b1);
						end
					end else if (cmd == "WAIT") begin
						repeat (a) tick();
					end else if (cmd == "PHASE") begin
						rc = $fscanf(fd, "%d", b);
						cmp_clk_phase_i = a[SEL_W-1:0];
						tgt_exp = cmp_phase_t'(b);
						tick();
						check_phase("cmp_phase_o", cmp_phase_o, tgt_exp);
					end else if (cmd == "SETTLE") begin
						wait_phase_done(cmp_phase_t'(a));
					end else if (cmd == "NOEN") begin
						b = cur_phase_o;
						repeat (a) begin
							tick();
							check_bit("ps_en_o while unlocked", ps_en_o, 1'b0);
						end
						check_phase("cur_phase_o while unlocked", cur_phase_o,
							cmp_phase_t'(b));
						check_bit("cmp_phs_change_o pending", cmp_phs_change_o, 1'b1);
					end else begin
						err_cnt++;
						$display("Unknown trace command %0s", cmd);
					end
				end
			end
			$fclose(fd);
		end
		close_test();
		$display("%0d tests, %0d failed, %0d errors", test_cnt, test_fail, err_cnt);
		if (err_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
clk_resync_pkg.sv
cmp_phase_pkg.sv
resync_ctrl.sv
cmp_phase_cfg.sv
cmp_phase_fsm.sv
clock_ctrl_top.sv
clock_ctrl_assertions.sv
tb_clock_ctrl.sv

/* clock_ctrl_trace.txt */
# Columns: command, then decimal arguments (PHASE takes setting and expected target)
# Commands: TEST name, RESET, LOCK, HALF, RESYNC hold, CHNG, HOLDOFF, DSRHI, WAIT, SETTLE, NOEN
TEST reset_release
LOCK 1
RESET
TEST resync
RESYNC 4
WAIT 9
RESYNC 1
WAIT 4
TEST sample_select
HALF 1
CHNG
WAIT 3
HALF 0
WAIT 2
RESYNC 3
HALF 1
CHNG
TEST holdoff
RESYNC 2
HOLDOFF 160
WAIT 10
RESYNC 2
DSRHI 80
CHNG
HOLDOFF 160
TEST phase_step
PHASE 5 217
SETTLE 217
PHASE 12 520
SETTLE 520
PHASE 3 130
SETTLE 130
TEST lock_gating
LOCK 0
PHASE 0 0
NOEN 40
LOCK 1
SETTLE 0
END
